// File: source/spi_bus_pkg.sv
`default_nettype none

package spi_bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // serial side word
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned spi_word_w = 8;  // bits per transfer

    // line usage, fixed for a whole frame
    typedef enum logic {
        mode_single = 1'b0,  // mosi in, miso out
        mode_dual   = 1'b1   // both lines, half duplex
    } spi_mode_e;

    //////////////////////////////////////////////////////////////////////
    // byte level traffic between serdes and decoder
    //////////////////////////////////////////////////////////////////////

    // received byte, stb is a one cycle pulse
    typedef struct packed {
        logic                  stb;  // byte complete
        logic [spi_word_w-1:0] dat;  // received byte, msb first on the wire
    } spi_req_t;

    // next byte to shift out
    typedef struct packed {
        logic                  dir;  // 1 - drive data lines
        logic [spi_word_w-1:0] dat;  // byte to send
    } spi_rsp_t;

endpackage: spi_bus_pkg

`default_nettype wire

// File: source/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

    import spi_bus_pkg::*;

    localparam int unsigned spi_adr_w = 6;  // address field of command byte

    // opcode, bit 0 write, bit 1 address increment
    typedef enum logic [1:0] {
        op_read      = 2'b00,
        op_write     = 2'b01,
        op_read_inc  = 2'b10,
        op_write_inc = 2'b11
    } spi_op_e;

    // first byte of every frame
    typedef struct packed {
        spi_op_e              op;   // bits 7:6
        logic [spi_adr_w-1:0] adr;  // start register
    } spi_cmd_t;

    // where the decoder is within a frame
    typedef enum logic [2:0] {
        ph_cmd    = 3'd0,  // waiting for command byte
        ph_turn   = 3'd1,  // turnaround byte of a read
        ph_read   = 3'd2,  // read data bytes
        ph_write  = 3'd3,  // write data bytes
        ph_ignore = 3'd4   // out of range read, send zeros
    } dec_phase_e;

    // one register access
    typedef struct packed {
        logic                  wen;
        logic                  ren;
        logic [spi_adr_w-1:0]  adr;
        logic [spi_word_w-1:0] wdt;
    } spi_acc_t;

endpackage: spi_cmd_pkg

`default_nettype wire

// File: source/spi_serdes.sv
`timescale 1ns/1ps
`default_nettype none

module spi_serdes import spi_bus_pkg::*; (
    input  logic       spi_sclk,  // mode 0 serial clock
    input  logic       spi_ss_n,  // select and async reset
    input  spi_mode_e  cfg_mod,   // single or dual
    input  logic [1:0] spi_io_i,  // {miso, mosi} in
    output logic [1:0] spi_io_o,  // {miso, mosi} out
    output logic [1:0] spi_io_e,  // {miso, mosi} enable
    output spi_req_t   req,       // received byte + strobe
    input  spi_rsp_t   rsp        // next byte to send
);

    localparam int unsigned cnt_w = $clog2(spi_word_w);

    logic [cnt_w-1:0]      bit_cnt;   // bits taken in this byte
    logic                  byte_end;  // edge capturing last bit
    logic [spi_word_w-1:0] sft;       // shift register
    logic [spi_word_w-1:0] sft_nxt;   // shifted value incl. new bits
    logic                  dir;       // latched line direction
    logic                  req_stb;
    logic [spi_word_w-1:0] req_dat;
    logic [1:0]            out_q;     // falling edge line driver
    logic                  oen_q;     // falling edge enable, dual mode

    //////////////////////////////////////////////////////////////////////
    // rising edge sampling and shifting
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (cfg_mod == mode_dual) begin
            byte_end = (bit_cnt == cnt_w'(spi_word_w - 2));
            sft_nxt  = {sft[spi_word_w-3:0], spi_io_i[1:0]};  // io[1] is msb
        end else begin
            byte_end = (bit_cnt == cnt_w'(spi_word_w - 1));
            sft_nxt  = {sft[spi_word_w-2:0], spi_io_i[0]};    // mosi only
        end
    end

    always_ff @(posedge spi_sclk, negedge spi_ss_n) begin
        if (!spi_ss_n) begin
            bit_cnt <= '0;
            sft     <= '0;
            dir     <= 1'b0;
            req_stb <= 1'b0;
        end else begin
            bit_cnt <= bit_cnt + ((cfg_mod == mode_dual) ? cnt_w'(2) : cnt_w'(1));
            req_stb <= byte_end;  // one cycle pulse
            if (byte_end) begin
                sft <= rsp.dat;   // next outgoing byte
                dir <= rsp.dir;
            end else begin
                sft <= sft_nxt;
            end
        end
    end

    // byte holds until the next byte end
    always_ff @(posedge spi_sclk) begin
        if (byte_end) req_dat <= sft_nxt;
    end

    assign req = '{stb: req_stb, dat: req_dat};

    //////////////////////////////////////////////////////////////////////
    // falling edge line drivers
    //////////////////////////////////////////////////////////////////////

    always_ff @(negedge spi_sclk, negedge spi_ss_n) begin
        if (!spi_ss_n) begin
            out_q <= 2'b00;
            oen_q <= 1'b0;
        end else begin
            if (cfg_mod == mode_dual) out_q <= sft[spi_word_w-1 -: 2];
            else                      out_q <= {sft[spi_word_w-1], 1'b0};
            oen_q <= dir;  // turn lines half a cycle after the load
        end
    end

    assign spi_io_o = out_q;
    // miso always driven in single mode
    assign spi_io_e = (cfg_mod == mode_dual) ? {2{oen_q}} : 2'b10;

    // mosi is never driven against the master in single mode
    a_single_en: assert property (@(posedge spi_sclk) disable iff (!spi_ss_n)
        (cfg_mod == mode_single) |-> (spi_io_e != 2'b11));

endmodule: spi_serdes

`default_nettype wire

// File: source/spi_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_decode import spi_bus_pkg::*; import spi_cmd_pkg::*; #(
    parameter int unsigned REG_NUM = 16  // power of two, 4..64
)(
    input  logic       spi_sclk,
    input  logic       spi_ss_n,
    input  spi_req_t   req,    // byte strobe from serdes
    output spi_acc_t   acc,    // register access
    output dec_phase_e phase   // frame position
);

    spi_cmd_t             cmd;      // strobed byte seen as command
    spi_op_e              op_q;     // opcode of this frame
    spi_op_e              cur_op;
    logic [spi_adr_w-1:0] adr_q;    // next access address
    logic [spi_adr_w-1:0] cur_adr;  // address for this strobe
    logic                 cur_ok;   // address within the bank
    logic                 acc_wen;
    logic                 acc_ren;
    logic [spi_adr_w-1:0] acc_adr;
    logic [spi_word_w-1:0] acc_wdt;

    // next address, wraps modulo REG_NUM for inc opcodes
    function automatic logic [spi_adr_w-1:0] step(
        input logic [spi_adr_w-1:0] adr,
        input spi_op_e              op
    );
        logic [spi_adr_w-1:0] nxt;
        nxt = (adr + spi_adr_w'(1)) & spi_adr_w'(REG_NUM - 1);
        return ((op == op_read_inc) || (op == op_write_inc)) ? nxt : adr;
    endfunction

    assign cmd     = spi_cmd_t'(req.dat);
    assign cur_op  = (phase == ph_cmd) ? cmd.op  : op_q;
    assign cur_adr = (phase == ph_cmd) ? cmd.adr : adr_q;
    assign cur_ok  = (cur_adr < REG_NUM);

    //////////////////////////////////////////////////////////////////////
    // phase machine
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge spi_sclk, negedge spi_ss_n) begin
        if (!spi_ss_n) begin
            phase   <= ph_cmd;
            op_q    <= op_read;
            adr_q   <= '0;
            acc_wen <= 1'b0;
            acc_ren <= 1'b0;
        end else begin
            acc_wen <= 1'b0;  // single cycle accesses
            acc_ren <= 1'b0;
            if (req.stb) begin
                case (phase)
                    ph_cmd: begin
                        op_q  <= cmd.op;
                        adr_q <= cmd.adr;
                        if ((cmd.op == op_write) || (cmd.op == op_write_inc)) begin
                            phase <= ph_write;  // range checked per byte
                        end else if (cur_ok) begin
                            phase   <= ph_turn;
                            acc_ren <= 1'b1;    // first read leaves in byte 2
                            adr_q   <= step(cur_adr, cur_op);
                        end else begin
                            phase <= ph_ignore;
                        end
                    end
                    ph_turn, ph_read: begin
                        phase   <= ph_read;
                        acc_ren <= 1'b1;        // prefetch two bytes ahead
                        adr_q   <= step(cur_adr, cur_op);
                    end
                    ph_write: begin
                        if (cur_ok) begin       // bad start address never steps
                            acc_wen <= 1'b1;
                            adr_q   <= step(cur_adr, cur_op);
                        end
                    end
                    default: ;                  // ignore until deselect
                endcase
            end
        end
    end

    always_ff @(posedge spi_sclk) begin
        if (req.stb) begin
            acc_adr <= cur_adr;
            acc_wdt <= req.dat;
        end
    end

    assign acc = '{wen: acc_wen, ren: acc_ren, adr: acc_adr, wdt: acc_wdt};

    a_acc_excl: assert property (@(posedge spi_sclk) disable iff (!spi_ss_n)
        !(acc.wen && acc.ren));

endmodule: spi_cmd_decode

`default_nettype wire

// File: source/spi_reg_execute.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_execute import spi_bus_pkg::*; import spi_cmd_pkg::*; #(
    parameter int unsigned REG_NUM = 16  // power of two, 4..64
)(
    input  logic                  spi_sclk,
    input  spi_acc_t              acc,  // decoded access
    output logic [spi_word_w-1:0] rdt   // read data, combinational
);

    localparam int unsigned adr_w = $clog2(REG_NUM);

    //////////////////////////////////////////////////////////////////////
    // register bank
    //////////////////////////////////////////////////////////////////////

    logic [spi_word_w-1:0] mem [REG_NUM];  // survives deselect
    logic [adr_w-1:0]      idx;            // bank index

    assign idx = acc.adr[adr_w-1:0];

    // write on strobe
    always_ff @(posedge spi_sclk) begin
        if (acc.wen) begin
            mem[idx] <= acc.wdt;
        end
    end

    // async read, sampled by the response block on acc.ren
    assign rdt = mem[idx];

    // decoder drops out of range writes
    a_wr_range: assert property (@(posedge spi_sclk)
        acc.wen |-> (acc.adr < REG_NUM));

endmodule: spi_reg_execute

`default_nettype wire

// File: source/spi_rsp_result.sv
`timescale 1ns/1ps
`default_nettype none

module spi_rsp_result import spi_bus_pkg::*; import spi_cmd_pkg::*; (
    input  logic                  spi_sclk,
    input  logic                  spi_ss_n,
    input  spi_acc_t              acc,    // access from decoder
    input  dec_phase_e            phase,  // frame position
    input  logic [spi_word_w-1:0] rdt,    // bank read data
    output spi_rsp_t              rsp     // next byte for serdes
);

    logic                  rsp_dir;
    logic [spi_word_w-1:0] rsp_dat;
    logic                  idle;  // no read traffic in this phase

    assign idle = (phase == ph_cmd) || (phase == ph_write);

    //////////////////////////////////////////////////////////////////////
    // response register, one edge after the access
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge spi_sclk, negedge spi_ss_n) begin
        if (!spi_ss_n) begin
            rsp_dir <= 1'b0;
        end else begin
            if (acc.ren)                 rsp_dir <= 1'b1;
            else if (phase == ph_ignore) rsp_dir <= 1'b1;  // bytes past turnaround
            else if (idle)               rsp_dir <= 1'b0;
            // turn/read hold between accesses
        end
    end

    always_ff @(posedge spi_sclk) begin
        if (acc.ren) begin
            rsp_dat <= rdt;
        end else if (idle || (phase == ph_ignore)) begin
            rsp_dat <= '0;  // zeros when nothing is read
        end
    end

    assign rsp = '{dir: rsp_dir, dat: rsp_dat};

    // lines only turn around inside a read frame
    a_dir_phase: assert property (@(posedge spi_sclk) disable iff (!spi_ss_n)
        rsp.dir |-> (phase inside {ph_turn, ph_read, ph_ignore}));

endmodule: spi_rsp_result

`default_nettype wire

// File: source/spi_reg_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_slave import spi_bus_pkg::*; import spi_cmd_pkg::*; #(
    parameter int unsigned REG_NUM = 16  // register count, power of two
)(
    input  logic       spi_sclk,
    input  logic       spi_ss_n,
    input  spi_mode_e  cfg_mod,   // steady for a frame
    input  logic [1:0] spi_io_i,  // {miso, mosi}
    output logic [1:0] spi_io_o,
    output logic [1:0] spi_io_e
);

    spi_req_t              req;    // serdes -> decoder
    spi_acc_t              acc;    // decoder -> bank, response
    dec_phase_e            phase;  // decoder -> response
    logic [spi_word_w-1:0] rdt;    // bank -> response
    spi_rsp_t              rsp;    // response -> serdes

    //////////////////////////////////////////////////////////////////////
    // byte pipeline
    //////////////////////////////////////////////////////////////////////

    spi_serdes serdes_inst (
        .spi_sclk (spi_sclk),
        .spi_ss_n (spi_ss_n),
        .cfg_mod  (cfg_mod),
        .spi_io_i (spi_io_i),
        .spi_io_o (spi_io_o),
        .spi_io_e (spi_io_e),
        .req      (req),
        .rsp      (rsp)
    );

    spi_cmd_decode #(.REG_NUM(REG_NUM)) decode_inst (
        .spi_sclk (spi_sclk),
        .spi_ss_n (spi_ss_n),
        .req      (req),
        .acc      (acc),
        .phase    (phase)
    );

    spi_reg_execute #(.REG_NUM(REG_NUM)) execute_inst (
        .spi_sclk (spi_sclk),
        .acc      (acc),
        .rdt      (rdt)
    );

    spi_rsp_result result_inst (
        .spi_sclk (spi_sclk),
        .spi_ss_n (spi_ss_n),
        .acc      (acc),
        .phase    (phase),
        .rdt      (rdt),
        .rsp      (rsp)
    );

endmodule: spi_reg_slave

`default_nettype wire

// File: verification/spi_reg_slave_check.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_slave_check import spi_bus_pkg::*; import spi_cmd_pkg::*; (
    input  logic       spi_sclk,
    input  logic       spi_ss_n,
    input  spi_mode_e  cfg_mod,
    input  logic [1:0] spi_io_i,  // master -> slave
    input  logic [1:0] spi_io_o,  // slave line values
    input  logic [1:0] spi_io_e,  // slave line enables
    output int         err_cnt,
    output int         chk_cnt
);

    localparam int reg_num = 16;

    logic [7:0] model [reg_num];  // expected bank contents
    logic       known [reg_num];
    int         bit_cnt;
    int         byte_idx;         // byte position in frame
    logic [7:0] in_sft;
    logic [7:0] out_sft;
    logic       is_read;
    logic       is_inc;
    logic       in_range;
    logic [5:0] cur_adr;

    initial begin : clear
        int i;
        err_cnt = 0;
        chk_cnt = 0;
        for (i = 0; i < reg_num; i++) known[i] = 1'b0;
    end

    // one complete byte seen on the pins
    task automatic take_byte(input logic [7:0] din, input logic [7:0] dout);
        logic [7:0] exp;
        if (byte_idx == 0) begin
            is_read  = !din[6];     // opcode bit 0 selects write
            is_inc   = din[7];
            cur_adr  = din[5:0];
            in_range = (din[5:0] < reg_num);
        end else if (!is_read) begin
            if (in_range) begin
                model[cur_adr] = din;
                known[cur_adr] = 1'b1;
                if (is_inc) cur_adr = (cur_adr + 1) % reg_num;
            end
        end else if (byte_idx >= 2) begin  // byte 1 is turnaround
            exp = in_range ? model[cur_adr] : 8'h00;
            if (!in_range || known[cur_adr]) begin
                chk_cnt = chk_cnt + 1;
                if (dout !== exp) begin
                    err_cnt = err_cnt + 1;
                    $display("mismatch spi_io_o byte %0d adr 0x%h: got 0x%h, expected 0x%h",
                             byte_idx, cur_adr, dout, exp);
                end
            end
            if (in_range && is_inc) cur_adr = (cur_adr + 1) % reg_num;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // rising edge sampling, pins are stable here
    //////////////////////////////////////////////////////////////////////

    always @(posedge spi_sclk) begin : watch
        logic [1:0] exp_e;
        if (cfg_mod == mode_single) exp_e = 2'b10;  // miso only, even in reset
        else if (!spi_ss_n)         exp_e = 2'b00;
        else                        exp_e = (is_read && byte_idx >= 2) ? 2'b11 : 2'b00;
        if (spi_io_e !== exp_e) begin
            err_cnt = err_cnt + 1;
            $display("mismatch spi_io_e byte %0d: got 0x%h, expected 0x%h",
                     byte_idx, spi_io_e, exp_e);
        end
        if (!spi_ss_n) begin
            bit_cnt  = 0;
            byte_idx = 0;
            is_read  = 1'b0;
        end else begin
            if (cfg_mod == mode_dual) begin
                in_sft  = {in_sft[5:0], spi_io_i};
                out_sft = {out_sft[5:0], spi_io_o};
                bit_cnt = bit_cnt + 2;
            end else begin
                in_sft  = {in_sft[6:0], spi_io_i[0]};   // mosi
                out_sft = {out_sft[6:0], spi_io_o[1]};  // miso
                bit_cnt = bit_cnt + 1;
            end
            if (bit_cnt == 8) begin
                take_byte(in_sft, out_sft);
                bit_cnt  = 0;
                byte_idx = byte_idx + 1;
            end
        end
    end

endmodule: spi_reg_slave_check

`default_nettype wire

// File: verification/spi_reg_slave_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_slave_tb import spi_bus_pkg::*; import spi_cmd_pkg::*; ();

    localparam int reg_num       = 16;
    localparam int n_directed    = 12;
    localparam int n_random      = 48;
    localparam int max_frame_cyc = 4 + 8 * (2 + reg_num);  // gap, tail and longest read burst
    localparam int cyc_limit     = (n_directed + n_random) * max_frame_cyc + 200;

    logic        spi_sclk = 1'b0;
    logic        spi_ss_n;
    spi_mode_e   cfg_mod;
    logic [1:0]  spi_io_i;
    logic [1:0]  spi_io_o;
    logic [1:0]  spi_io_e;
    int          err_cnt;    // from checker
    int          chk_cnt;    // read bytes compared
    int          frame_cnt = 0;
    int          cyc_cnt   = 0;
    logic [15:0] lfsr;
    logic [7:0]  byte_q [$];  // master side bytes of the next frame

    always #10 spi_sclk = ~spi_sclk;  // 20 ns

    spi_reg_slave #(.REG_NUM(reg_num)) spi_reg_slave_inst (
        .spi_sclk (spi_sclk),
        .spi_ss_n (spi_ss_n),
        .cfg_mod  (cfg_mod),
        .spi_io_i (spi_io_i),
        .spi_io_o (spi_io_o),
        .spi_io_e (spi_io_e)
    );

    spi_reg_slave_check check_inst (
        .spi_sclk (spi_sclk),
        .spi_ss_n (spi_ss_n),
        .cfg_mod  (cfg_mod),
        .spi_io_i (spi_io_i),
        .spi_io_o (spi_io_o),
        .spi_io_e (spi_io_e),
        .err_cnt  (err_cnt),
        .chk_cnt  (chk_cnt)
    );

    //////////////////////////////////////////////////////////////////////
    // fibonacci lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    //////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit
    function automatic int unsigned take_bits(input int n);
        int unsigned v;
        int          k;
        v = 0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v    = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // frame driver with mosi changing on the falling edge
    //////////////////////////////////////////////////////////////////////

    // entered on a falling edge and left on one with the slave deselected
    task automatic send_frame(input spi_mode_e mode);
        logic [7:0] b;
        int         nb;
        spi_ss_n = 1'b0;   // 2 cycle reset gap
        cfg_mod  = mode;   // only changes while deselected
        spi_io_i = 2'b00;
        repeat (2) @(negedge spi_sclk);
        spi_ss_n = 1'b1;
        while (byte_q.size() > 0) begin
            b = byte_q.pop_front();
            if (mode == mode_dual) begin
                for (nb = 0; nb < 4; nb++) begin
                    spi_io_i = b[7 - 2 * nb -: 2];  // io[1] is the upper bit
                    @(negedge spi_sclk);
                end
            end else begin
                for (nb = 0; nb < 8; nb++) begin
                    spi_io_i = {1'b0, b[7 - nb]};  // msb first
                    @(negedge spi_sclk);
                end
            end
        end
        spi_io_i = 2'b00;
        repeat (2) @(negedge spi_sclk);  // two more edges finish the last access
        spi_ss_n  = 1'b0;
        frame_cnt = frame_cnt + 1;
    endtask

    // command byte followed by data or by turnaround and filler
    task automatic run_frame(input spi_mode_e mode, input spi_op_e op,
                             input logic [5:0] adr, input int len);
        logic [1:0] opb;
        int         i;
        opb = op;
        byte_q.push_back({opb, adr});
        if (!opb[0]) byte_q.push_back(8'(take_bits(8)));  // ignored turnaround
        for (i = 0; i < len; i++) begin
            byte_q.push_back(8'(take_bits(8)));  // write data or don't care
        end
        send_frame(mode);
    endtask

    initial begin : stim
        spi_mode_e  mode;
        spi_op_e    op;
        logic [5:0] adr;
        int         len;
        int         i;
        lfsr     = 16'd39265;
        spi_ss_n = 1'b0;
        cfg_mod  = mode_single;
        spi_io_i = 2'b00;
        // directed part writes the whole bank first
        run_frame(mode_single, op_write_inc, 6'd0, reg_num);
        run_frame(mode_single, op_write, 6'd5, 1);
        run_frame(mode_single, op_read, 6'd5, 1);
        run_frame(mode_single, op_write_inc, 6'd14, 4);  // wraps to 0 and 1
        run_frame(mode_dual, op_read_inc, 6'd14, 4);
        run_frame(mode_dual, op_write, 6'd3, 3);         // last byte sticks
        run_frame(mode_single, op_read, 6'd3, 3);
        run_frame(mode_single, op_write_inc, 6'd40, 4);  // out of range
        run_frame(mode_dual, op_write, 6'd16, 2);
        run_frame(mode_dual, op_read_inc, 6'd0, reg_num);
        run_frame(mode_single, op_read, 6'd50, 3);
        run_frame(mode_dual, op_read_inc, 6'd20, 2);
        // random part
        for (i = 0; i < n_random; i++) begin
            mode = spi_mode_e'(1'(take_bits(1)));
            op   = spi_op_e'(2'(take_bits(2)));
            if (take_bits(3) == 0) adr = 6'd16 | 6'(take_bits(6));  // rare bad address
            else                   adr = 6'(take_bits(4));
            len = 1 + take_bits(3) % 6;
            run_frame(mode, op, adr, len);
        end
        repeat (3) @(negedge spi_sclk);
        if (chk_cnt == 0) $display("no read bytes were compared");
        $display("frames %0d, read bytes compared %0d, errors %0d",
                 frame_cnt, chk_cnt, err_cnt);
        if ((err_cnt == 0) && (chk_cnt > 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // run length guard
    always @(posedge spi_sclk) begin
        cyc_cnt = cyc_cnt + 1;
        if (cyc_cnt >= cyc_limit) begin
            $display("timeout after %0d cycles, frames %0d, errors %0d",
                     cyc_cnt, frame_cnt, err_cnt);
            $display("Test failed");
            $finish;
        end
    end

endmodule: spi_reg_slave_tb

`default_nettype wire

// File: spi_reg_slave.f
source/spi_bus_pkg.sv
source/spi_cmd_pkg.sv
source/spi_serdes.sv
source/spi_cmd_decode.sv
source/spi_reg_execute.sv
source/spi_rsp_result.sv
source/spi_reg_slave.sv
verification/spi_reg_slave_check.sv
verification/spi_reg_slave_tb.sv

// File: Bender.yml
package:
  name: spi_reg_slave

sources:
  - source/spi_bus_pkg.sv
  - source/spi_cmd_pkg.sv
  - source/spi_serdes.sv
  - source/spi_cmd_decode.sv
  - source/spi_reg_execute.sv
  - source/spi_rsp_result.sv
  - source/spi_reg_slave.sv
  - target: test
    files:
      - verification/spi_reg_slave_check.sv
      - verification/spi_reg_slave_tb.sv
